//--- design/dly_pkg.sv
package dly_pkg;

    ////////////////////
    // Sizes and site map
    ////////////////////
    localparam int NUM_GB_SITES  = 20;                              // Gearbox delay sites
    localparam logic [NUM_GB_SITES-1:0] DLY_LOC = 20'h0_C117;       // Set bit = site holds a delay
    localparam int NUM_DLY       = 7;                               // Popcount of DLY_LOC
    localparam int ADDR_WIDTH    = 5;                               // Site address width
    localparam int DLY_TAP_WIDTH = 6;
    localparam logic [DLY_TAP_WIDTH-1:0] TAP_MAX = 6'd63;           // Saturation ceiling

    // Operation codes carried by a user command
    typedef enum logic [1:0] {
        OP_CLR = 2'd0,                                              // Tap back to 0
        OP_INC = 2'd1,                                              // Step up by one
        OP_DEC = 2'd2                                               // Step down by one
    } dly_op_e;

    typedef struct packed {
        logic [2:0] ch;                                             // Logical channel
        dly_op_e    op;
    } dly_cmd_t;

    // Shared control bus towards the gearbox
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;                                // Physical site
        logic                  ld;                                  // Load strobe
        logic                  adj;                                 // 0 clears, 1 steps
        logic                  incdec;                              // Step direction, 1 is up
    } dly_ctrl_t;

    // Site of logical channel k, i.e. index of the k-th set bit of DLY_LOC
    function automatic logic [ADDR_WIDTH-1:0] dly_site_addr_f(input int unsigned k);
        int unsigned           cnt;
        logic [ADDR_WIDTH-1:0] addr;
        cnt  = 0;
        addr = '0;
        for (int i = 0; i < NUM_GB_SITES; i++) begin
            if (DLY_LOC[i]) begin
                if (cnt == k) addr = ADDR_WIDTH'(i);                // Ordinal match
                cnt++;
            end
        end
        return addr;
    endfunction

endpackage

//--- design/muxp.sv
`timescale 1ns/100ps

// One-hot select of NUM_OF_BUS equal buses, zero when nothing is selected
module muxp #(
    parameter int DWIDTH     = 1,
    parameter int NUM_OF_BUS = 2
) (
    input  logic [NUM_OF_BUS*DWIDTH-1:0] d,      // Concatenated buses, bus 0 in the LSBs
    input  logic [NUM_OF_BUS-1:0]        sel,    // One-hot or zero
    output logic [DWIDTH-1:0]            dout
);

    ////////////////////
    // AND-OR tree
    ////////////////////
    always_comb begin
        dout = '0;
        for (int i = 0; i < NUM_OF_BUS; i++) begin
            // Gate each slice by its select bit then merge
            dout |= d[i*DWIDTH +: DWIDTH] & {DWIDTH{sel[i]}};
        end
    end

    // More than one select set would OR the buses together,
    // so the caller keeps sel one-hot

endmodule

//--- design/one2x_decoder.sv
`timescale 1ns/100ps

// Steer one word onto the selected slices of a wide bus
module one2x_decoder #(
    parameter int DWIDTH      = 1,
    parameter int NUM_OF_OBUS = 2
) (
    input  logic [DWIDTH-1:0]             din,
    input  logic [NUM_OF_OBUS-1:0]        sel,   // Slice enables
    output logic [NUM_OF_OBUS*DWIDTH-1:0] dout   // Slice 0 in the LSBs
);

    always_comb begin
        for (int i = 0; i < NUM_OF_OBUS; i++) begin
            // Unselected slices read as zero
            dout[i*DWIDTH +: DWIDTH] = sel[i] ? din : '0;
        end
    end

endmodule

//--- design/dly_addr_cntrl.sv
`timescale 1ns/100ps

// Delay address controller
// Maps the active channel to its gearbox site and multiplexes the strobes
// onto the shared control bus, readback goes the other way
module dly_addr_cntrl (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic [dly_pkg::NUM_DLY-1:0]                      usr_dly_ld,       // One-hot, selects the site
    input  logic [dly_pkg::NUM_DLY-1:0]                      usr_dly_adj,
    input  logic [dly_pkg::NUM_DLY-1:0]                      usr_dly_incdec,
    input  logic [dly_pkg::NUM_DLY-1:0]                      usr_rd_dly_value, // One-hot readback request
    input  logic [dly_pkg::DLY_TAP_WIDTH-1:0]                cntrl_dly_tap_value,
    output dly_pkg::dly_ctrl_t                               ctrl,
    output logic [dly_pkg::NUM_DLY*dly_pkg::DLY_TAP_WIDTH-1:0] usr_dly_tap_value_out
);
    import dly_pkg::*;

    logic [ADDR_WIDTH*NUM_DLY-1:0] dly_site_addr_bus;   // Channel-to-site table, ch 0 in LSBs
    logic [ADDR_WIDTH-1:0]         sel_addr;
    logic                          sel_ld;
    logic                          sel_adj;
    logic                          sel_incdec;
    logic [NUM_DLY-1:0]            usr_dly_ld_en;       // Readback slice select

    ////////////////////
    // Site address table
    ////////////////////
    for (genvar i = 0; i < NUM_DLY; i++) begin : g_addr_tbl
        assign dly_site_addr_bus[i*ADDR_WIDTH +: ADDR_WIDTH] = dly_site_addr_f(i);
    end

    ////////////////////
    // Strobe steering, all selected by ld
    ////////////////////
    muxp #(.DWIDTH(ADDR_WIDTH), .NUM_OF_BUS(NUM_DLY)) u_mux_addr (
        .d    (dly_site_addr_bus),
        .sel  (usr_dly_ld),
        .dout (sel_addr)
    );

    muxp #(.DWIDTH(1), .NUM_OF_BUS(NUM_DLY)) u_mux_ld (
        .d    (usr_dly_ld),                         // Self-selected, high iff any ld
        .sel  (usr_dly_ld),
        .dout (sel_ld)
    );

    muxp #(.DWIDTH(1), .NUM_OF_BUS(NUM_DLY)) u_mux_adj (
        .d    (usr_dly_adj),
        .sel  (usr_dly_ld),
        .dout (sel_adj)
    );

    muxp #(.DWIDTH(1), .NUM_OF_BUS(NUM_DLY)) u_mux_incdec (
        .d    (usr_dly_incdec),
        .sel  (usr_dly_ld),
        .dout (sel_incdec)
    );

    assign ctrl = '{addr: sel_addr, ld: sel_ld, adj: sel_adj, incdec: sel_incdec};

    ////////////////////
    // Readback routing
    ////////////////////
    assign usr_dly_ld_en = usr_rd_dly_value ^ usr_dly_ld;   // Either strobe opens the slice

    one2x_decoder #(.DWIDTH(DLY_TAP_WIDTH), .NUM_OF_OBUS(NUM_DLY)) u_rd_dec (
        .din  (cntrl_dly_tap_value),
        .sel  (usr_dly_ld_en),
        .dout (usr_dly_tap_value_out)
    );

    // Sequencer must never load and read in the same cycle,
    // nor touch more than one channel at once
    a_strobe_onehot : assert property (@(posedge clk) disable iff (!rst)
        $onehot0(usr_dly_ld) && $onehot0(usr_rd_dly_value) &&
        !((|usr_dly_ld) && (|usr_rd_dly_value)));

endmodule

//--- design/dly_cmd_seq.sv
`timescale 1ns/100ps

// Command sequencer
// Four-phase req/ack on the user side and one-hot strobes on the controller side
module dly_cmd_seq (
    input  logic                                               clk,
    input  logic                                               rst,
    input  dly_pkg::dly_cmd_t                                  cmd,
    input  logic                                               req,
    output logic                                               ack,
    output logic [dly_pkg::NUM_DLY-1:0]                        usr_dly_ld,
    output logic [dly_pkg::NUM_DLY-1:0]                        usr_dly_adj,
    output logic [dly_pkg::NUM_DLY-1:0]                        usr_dly_incdec,
    output logic [dly_pkg::NUM_DLY-1:0]                        usr_rd_dly_value,
    input  logic [dly_pkg::NUM_DLY*dly_pkg::DLY_TAP_WIDTH-1:0] usr_dly_tap_value_out,
    output logic [dly_pkg::NUM_DLY*dly_pkg::DLY_TAP_WIDTH-1:0] tap_values
);
    import dly_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,     // Waiting for req
        S_OP,       // ld/adj/incdec strobes out
        S_RD,       // Readback strobe for two cycles
        S_ACK       // Holding ack until req drops
    } state_t;

    state_t                   state;
    dly_cmd_t                 cmd_q;                    // Latched at req
    logic                     rd_last;                  // Second RD cycle
    logic [NUM_DLY-1:0]       ch_oh;                    // One-hot of latched channel
    logic [DLY_TAP_WIDTH-1:0] shadow [NUM_DLY];         // Last tap per channel

    ////////////////////
    // FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= S_IDLE;
            rd_last <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (req) state <= S_OP;
                S_OP:   state <= S_RD;
                S_RD: begin
                    rd_last <= ~rd_last;
                    if (rd_last) state <= S_ACK;        // Readout is valid by now
                end
                S_ACK:  if (!req) state <= S_IDLE;      // Drop ack one cycle after req
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req) cmd_q <= cmd;      // Command payload
    end

    ////////////////////
    // Strobes
    ////////////////////
    assign ch_oh = NUM_DLY'(1) << cmd_q.ch;

    assign usr_dly_ld       = (state == S_OP) ? ch_oh : '0;
    assign usr_dly_adj      = (state == S_OP && cmd_q.op != OP_CLR) ? ch_oh : '0; // Clear has adj low
    assign usr_dly_incdec   = (state == S_OP && cmd_q.op == OP_INC) ? ch_oh : '0;
    assign usr_rd_dly_value = (state == S_RD) ? ch_oh : '0;
    assign ack              = (state == S_ACK);

    ////////////////////
    // Shadow taps
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_DLY; i++) shadow[i] <= '0;
        end else if (state == S_RD && rd_last) begin
            // Closing edge of RD is also the edge that raises ack
            shadow[cmd_q.ch] <= usr_dly_tap_value_out[cmd_q.ch*DLY_TAP_WIDTH +: DLY_TAP_WIDTH];
        end
    end

    for (genvar i = 0; i < NUM_DLY; i++) begin : g_tap_out
        assign tap_values[i*DLY_TAP_WIDTH +: DLY_TAP_WIDTH] = shadow[i];
    end

    // ack may only drop once the FSM has already seen req low
    a_ack_hold : assert property (@(posedge clk) disable iff (!rst)
        $fell(ack) |-> !$past(req));

endmodule

//--- design/gb_dly_bank.sv
`timescale 1ns/100ps

// Behavioural gearbox delay bank, one tap counter per site
module gb_dly_bank (
    input  logic                              clk,
    input  logic                              rst,
    input  dly_pkg::dly_ctrl_t                ctrl,
    output logic [dly_pkg::DLY_TAP_WIDTH-1:0] cntrl_dly_tap_value    // Tap of latched site
);
    import dly_pkg::*;

    logic [DLY_TAP_WIDTH-1:0] taps [NUM_GB_SITES];
    logic [ADDR_WIDTH-1:0]    site_q;                   // Latched on ld
    logic [DLY_TAP_WIDTH-1:0] tap_cur;
    logic [DLY_TAP_WIDTH-1:0] tap_nxt;

    ////////////////////
    // Next tap
    ////////////////////
    always_comb begin
        tap_cur = taps[ctrl.addr];
        if (!ctrl.adj) begin
            tap_nxt = '0;                                                   // Load clears
        end else if (ctrl.incdec) begin
            tap_nxt = (tap_cur == TAP_MAX) ? tap_cur : tap_cur + 1'b1;      // Saturate high
        end else begin
            tap_nxt = (tap_cur == '0) ? tap_cur : tap_cur - 1'b1;           // Saturate low
        end
    end

    ////////////////////
    // Counters and site latch
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_GB_SITES; i++) taps[i] <= '0;
            site_q <= '0;
        end else if (ctrl.ld) begin
            taps[ctrl.addr] <= tap_nxt;
            site_q          <= ctrl.addr;
        end
    end

    // Registered readout, one cycle behind the counters
    always_ff @(posedge clk) begin
        if (!rst) begin
            cntrl_dly_tap_value <= '0;
        end else begin
            cntrl_dly_tap_value <= taps[site_q];
        end
    end

    // The controller's site map must only ever point at populated sites
    a_ld_site_valid : assert property (@(posedge clk) disable iff (!rst)
        ctrl.ld |-> (ctrl.addr < NUM_GB_SITES) && DLY_LOC[ctrl.addr]);

endmodule

//--- design/dly_ctrl_top.sv
`timescale 1ns/100ps

// Delay control subsystem
// sequencer -> address controller -> gearbox bank, readback loops back
module dly_ctrl_top (
    input  logic                                               clk,
    input  logic                                               rst,
    input  dly_pkg::dly_cmd_t                                  cmd,
    input  logic                                               req,
    output logic                                               ack,
    output logic [dly_pkg::NUM_DLY*dly_pkg::DLY_TAP_WIDTH-1:0] tap_values   // Per-channel taps
);
    import dly_pkg::*;

    logic [NUM_DLY-1:0]               usr_dly_ld;
    logic [NUM_DLY-1:0]               usr_dly_adj;
    logic [NUM_DLY-1:0]               usr_dly_incdec;
    logic [NUM_DLY-1:0]               usr_rd_dly_value;
    logic [NUM_DLY*DLY_TAP_WIDTH-1:0] usr_dly_tap_value_out;  // Decoded readback
    logic [DLY_TAP_WIDTH-1:0]         cntrl_dly_tap_value;    // Raw gearbox readout
    dly_ctrl_t                        ctrl;                   // Shared control bus

    ////////////////////
    // Sequencer
    ////////////////////
    dly_cmd_seq u_dly_cmd_seq (
        .clk                   (clk),
        .rst                   (rst),
        .cmd                   (cmd),
        .req                   (req),
        .ack                   (ack),
        .usr_dly_ld            (usr_dly_ld),
        .usr_dly_adj           (usr_dly_adj),
        .usr_dly_incdec        (usr_dly_incdec),
        .usr_rd_dly_value      (usr_rd_dly_value),
        .usr_dly_tap_value_out (usr_dly_tap_value_out),
        .tap_values            (tap_values)
    );

    // Channel to site, combinational
    dly_addr_cntrl u_dly_addr_cntrl (
        .clk                   (clk),
        .rst                   (rst),
        .usr_dly_ld            (usr_dly_ld),
        .usr_dly_adj           (usr_dly_adj),
        .usr_dly_incdec        (usr_dly_incdec),
        .usr_rd_dly_value      (usr_rd_dly_value),
        .cntrl_dly_tap_value   (cntrl_dly_tap_value),
        .ctrl                  (ctrl),
        .usr_dly_tap_value_out (usr_dly_tap_value_out)
    );

    gb_dly_bank u_gb_dly_bank (
        .clk                 (clk),
        .rst                 (rst),
        .ctrl                (ctrl),
        .cntrl_dly_tap_value (cntrl_dly_tap_value)
    );

endmodule

//--- verif/tb_dly_ctrl.sv
`timescale 1ns/100ps

module tb_dly_ctrl;
    import dly_pkg::*;

    localparam int RST_CYC     = 8;
    localparam int NUM_CMDS    = 1 + 21 + 140 + 22 + 200;     // Commands over all tests
    localparam int TIMEOUT_CYC = 40 * NUM_CMDS + RST_CYC;

    logic                             clk;
    logic                             rst;
    dly_cmd_t                         cmd;
    logic                             req;
    logic                             ack;
    logic [NUM_DLY*DLY_TAP_WIDTH-1:0] tap_values;
    logic [NUM_DLY*DLY_TAP_WIDTH-1:0] exp_vec;      // Reference readback packed like tap_values
    int                               ref_tap [NUM_DLY];
    int                               err_cnt;
    int                               tests_run;
    int                               tests_failed;
    int                               cycle_cnt;
    int                               err_start;

    dly_ctrl_top u_dly_ctrl_top (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .req        (req),
        .ack        (ack),
        .tap_values (tap_values)
    );

    always #4 clk = ~clk;                          // 8 ns period

    ////////////////////
    // Checkers
    ////////////////////
    a_rst_ack : assert property (@(posedge clk) $rose(rst) |-> !ack)
        else begin
            $display("mismatch ack exp=%h got=%h", 1'b0, $sampled(ack));
            err_cnt++;
        end

    a_rst_taps : assert property (@(posedge clk) $rose(rst) |-> tap_values == '0)
        else begin
            $display("mismatch tap_values exp=%h got=%h", '0, $sampled(tap_values));
            err_cnt++;
        end

    // ack stays low through the third edge after req is seen and samples high on the fourth
    a_ack_rise : assert property (@(posedge clk) disable iff (!rst)
        $rose(req) |-> !ack [*4] ##1 ack)
        else begin
            $display("ack did not rise exactly three cycles after req was seen");
            err_cnt++;
        end

    a_ack_fall : assert property (@(posedge clk) disable iff (!rst)
        $fell(req) |-> ack ##1 !ack)
        else begin
            $display("ack did not fall one cycle after req dropped");
            err_cnt++;
        end

    a_readback : assert property (@(posedge clk) disable iff (!rst)
        $rose(ack) |-> tap_values == exp_vec)
        else begin
            $display("mismatch tap_values exp=%h got=%h", $sampled(exp_vec),
                     $sampled(tap_values));
            err_cnt++;
        end

    ////////////////////
    // Reference model and stimulus
    ////////////////////
    // Tap after one op under the bank rule
    function automatic int next_tap(input int cur, input dly_op_e op);
        int t;
        case (op)
            OP_CLR:  t = 0;
            OP_INC:  t = (cur + 1 > TAP_MAX) ? TAP_MAX : cur + 1;
            OP_DEC:  t = (cur - 1 < 0) ? 0 : cur - 1;
            default: t = cur;                      // Unused code leaves the tap alone
        endcase
        return t;
    endfunction

    // One full four-phase transfer
    task automatic issue_cmd(input int ch, input dly_op_e op);
        @(posedge clk);
        #1;
        cmd.ch  = 3'(ch);
        cmd.op  = op;
        req     = 1'b1;
        ref_tap[ch] = next_tap(ref_tap[ch], op);
        for (int i = 0; i < NUM_DLY; i++) begin
            exp_vec[i*DLY_TAP_WIDTH +: DLY_TAP_WIDTH] = DLY_TAP_WIDTH'(ref_tap[i]);
        end
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        req = 1'b0;                                // cmd stays put until the next transfer
        do begin
            @(posedge clk);
            #1;
        end while (ack);
    endtask

    task automatic report_test(input int num, input string name);
        repeat (2) @(posedge clk);                 // Let trailing checks settle
        tests_run++;
        if (err_cnt == err_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", num, name, err_cnt - err_start);
        end
        err_start = err_cnt;
    endtask

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYC) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        req = 1'b0;
        cmd = '{ch: 3'd0, op: OP_CLR};
        exp_vec = '0;
        err_cnt = 0;
        err_start = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < NUM_DLY; i++) ref_tap[i] = 0;
        void'($urandom(4));

        repeat (RST_CYC) @(posedge clk);
        #1;
        rst = 1'b1;
        report_test(1, "reset state");

        issue_cmd(0, OP_INC);                       // Single transfer for the a_ack_* checks
        report_test(2, "handshake");

        for (int ch = 0; ch < NUM_DLY; ch++) begin
            repeat (3) issue_cmd(ch, OP_INC);       // Each slice steps while the others hold
        end
        report_test(3, "inc per channel");

        repeat (70) issue_cmd(6, OP_INC);           // Top saturation
        repeat (70) issue_cmd(6, OP_DEC);           // Bottom saturation
        report_test(4, "saturation");

        repeat (10) issue_cmd(3, OP_INC);
        issue_cmd(3, OP_CLR);
        repeat (10) issue_cmd(1, OP_INC);
        issue_cmd(1, OP_CLR);
        report_test(5, "clear");

        for (int n = 0; n < 200; n++) begin
            repeat ($urandom_range(2, 0)) @(posedge clk);   // Random idle gap
            issue_cmd($urandom_range(NUM_DLY - 1, 0), dly_op_e'($urandom_range(2, 0)));
        end
        report_test(6, "random commands");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/dly_pkg.sv
design/muxp.sv
design/one2x_decoder.sv
design/dly_addr_cntrl.sv
design/dly_cmd_seq.sv
design/gb_dly_bank.sv
design/dly_ctrl_top.sv
verif/tb_dly_ctrl.sv
